// File: source/board_pkg.sv
`default_nettype none

package board_pkg;

   // One serial data byte
   typedef logic [7:0] byte_t;

   // Index of the data bit on the line
   typedef logic [2:0] bit_idx_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   // Sysclk cycles per serial bit, 100 MHz at 115200 baud
   localparam int CLKS_PER_BIT_DEFAULT = 868;

   // Width of the power-on reset stretch counter
   localparam int RESET_CNT_W_DEFAULT = 16;

endpackage

`default_nettype wire

// File: source/reset_stretch.sv
`default_nettype none

module reset_stretch #(
   parameter int RESET_CNT_W = board_pkg::RESET_CNT_W_DEFAULT
) (
   input  wire  sysclk,
   input  wire  arst,
   output logic reset_int
);

   localparam logic [RESET_CNT_W-1:0] CNT_MAX = '1;

   logic [RESET_CNT_W-1:0] reset_cnt;

   // Saturates at all ones and stays there until the next arst
   always_ff @(posedge sysclk or posedge arst) begin
      if (arst) begin
         reset_cnt <= '0;
      end else if (reset_cnt != CNT_MAX) begin
         reset_cnt <= reset_cnt + 1'b1;
      end
   end

   assign reset_int = (reset_cnt != CNT_MAX);

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = board_pkg::CLKS_PER_BIT_DEFAULT
) (
   input  wire              sysclk,
   input  wire              reset_int,
   input  wire              uart_rxd,
   output board_pkg::byte_t rx_data,
   output logic             rx_valid,
   output logic             rx_frame_err
);

   import board_pkg::*;

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);

   rx_state_t        state;
   logic [CNT_W-1:0] clk_cnt;
   bit_idx_t         bit_idx;
   byte_t            shift_q;
   logic             rxd_meta;
   logic             rxd_sync;

   // Two-flop synchronizer, idle line is high
   always_ff @(posedge sysclk or posedge reset_int) begin
      if (reset_int) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= uart_rxd;
         rxd_sync <= rxd_meta;
      end
   end

   always_ff @(posedge sysclk or posedge reset_int) begin
      if (reset_int) begin
         state        <= RX_IDLE;
         clk_cnt      <= '0;
         bit_idx      <= '0;
         rx_valid     <= 1'b0;
         rx_frame_err <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               bit_idx <= '0;
               if (!rxd_sync) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               // Recheck at mid-bit so a short glitch is dropped
               if (clk_cnt == HALF_BIT) begin
                  clk_cnt <= '0;
                  state   <= rxd_sync ? RX_IDLE : RX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (clk_cnt == BIT_LAST) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (clk_cnt == BIT_LAST) begin
                  clk_cnt      <= '0;
                  rx_valid     <= 1'b1;
                  rx_frame_err <= ~rxd_sync;
                  state        <= RX_IDLE;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge sysclk) begin
      if (state == RX_DATA && clk_cnt == BIT_LAST) begin
         shift_q <= {rxd_sync, shift_q[7:1]};
      end
      if (state == RX_STOP && clk_cnt == BIT_LAST) begin
         rx_data <= shift_q;
      end
   end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = board_pkg::CLKS_PER_BIT_DEFAULT
) (
   input  wire              sysclk,
   input  wire              reset_int,
   input  wire board_pkg::byte_t tx_data,
   input  wire              tx_start,
   output logic             uart_txd,
   output logic             tx_busy
);

   import board_pkg::*;

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

   tx_state_t        state;
   logic [CNT_W-1:0] clk_cnt;
   bit_idx_t         bit_idx;
   byte_t            shift_q;

   always_ff @(posedge sysclk or posedge reset_int) begin
      if (reset_int) begin
         state    <= TX_IDLE;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         uart_txd <= 1'b1;
      end else begin
         case (state)
            TX_IDLE: begin
               clk_cnt  <= '0;
               bit_idx  <= '0;
               uart_txd <= 1'b1;
               if (tx_start) begin
                  uart_txd <= 1'b0;
                  state    <= TX_START;
               end
            end
            TX_START, TX_DATA: begin
               if (clk_cnt == BIT_LAST) begin
                  clk_cnt <= '0;
                  if (state == TX_DATA && bit_idx == 3'd7) begin
                     uart_txd <= 1'b1;
                     state    <= TX_STOP;
                  end else begin
                     uart_txd <= shift_q[0];
                     if (state == TX_DATA) begin
                        bit_idx <= bit_idx + 1'b1;
                     end
                     state <= TX_DATA;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            TX_STOP: begin
               if (clk_cnt == BIT_LAST) begin
                  clk_cnt <= '0;
                  state   <= TX_IDLE;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // Byte latched on start, then shifted out LSB first
   always_ff @(posedge sysclk) begin
      if (state == TX_IDLE && tx_start) begin
         shift_q <= tx_data;
      end else if (state != TX_IDLE && state != TX_STOP && clk_cnt == BIT_LAST) begin
         shift_q <= {1'b0, shift_q[7:1]};
      end
   end

   assign tx_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

// File: source/system.sv
`default_nettype none

module system #(
   parameter int CLKS_PER_BIT = board_pkg::CLKS_PER_BIT_DEFAULT
) (
   input  wire  sysclk,
   input  wire  reset_int,
   input  wire  uart_rxd,
   output logic uart_txd,
   output logic trap
);

   import board_pkg::*;

   byte_t rx_data;
   logic  rx_valid;
   logic  rx_frame_err;
   byte_t buf_q;
   logic  buf_full;
   logic  tx_start;
   logic  tx_busy;

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uart_rx0 (
      .sysclk       (sysclk),
      .reset_int    (reset_int),
      .uart_rxd     (uart_rxd),
      .rx_data      (rx_data),
      .rx_valid     (rx_valid),
      .rx_frame_err (rx_frame_err)
   );

   // A byte arriving while full replaces the held one
   always_ff @(posedge sysclk or posedge reset_int) begin
      if (reset_int) begin
         buf_full <= 1'b0;
         trap     <= 1'b0;
      end else begin
         if (rx_valid && !rx_frame_err) begin
            buf_full <= 1'b1;
         end else if (tx_start) begin
            buf_full <= 1'b0;
         end
         if (rx_valid && rx_frame_err) begin
            trap <= 1'b1;
         end
      end
   end

   always_ff @(posedge sysclk) begin
      if (rx_valid && !rx_frame_err) begin
         buf_q <= rx_data;
      end
   end

   assign tx_start = buf_full & ~tx_busy;

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uart_tx0 (
      .sysclk    (sysclk),
      .reset_int (reset_int),
      .tx_data   (buf_q),
      .tx_start  (tx_start),
      .uart_txd  (uart_txd),
      .tx_busy   (tx_busy)
   );

endmodule

`default_nettype wire

// File: source/top_system.sv
`default_nettype none

module top_system #(
   parameter int CLKS_PER_BIT = board_pkg::CLKS_PER_BIT_DEFAULT,
   parameter int RESET_CNT_W  = board_pkg::RESET_CNT_W_DEFAULT
) (
   input  wire  sysclk,
   input  wire  arst,
   input  wire  uart_rxd,
   output logic uart_txd,
   output logic trap
);

   wire reset_int;

   // Core stays in reset for a while after the board reset lets go
   reset_stretch #(
      .RESET_CNT_W (RESET_CNT_W)
   ) reset_stretch0 (
      .sysclk    (sysclk),
      .arst      (arst),
      .reset_int (reset_int)
   );

   system #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) system0 (
      .sysclk    (sysclk),
      .reset_int (reset_int),
      .uart_rxd  (uart_rxd),
      .uart_txd  (uart_txd),
      .trap      (trap)
   );

endmodule

`default_nettype wire

// File: verification/tb_top_system.sv
`default_nettype none

module tb_top_system;

   import board_pkg::*;

   localparam int CLKS_PER_BIT     = 8;
   localparam int RESET_CNT_W      = 4;
   localparam int CLK_PERIOD       = 40;
   localparam int RESET_CYCLES     = 5;
   localparam int STRETCH_CYCLES   = (1 << RESET_CNT_W) - 1;
   localparam int PHASE1_FRAMES    = 40;
   localparam int PHASE2_FRAMES    = 16;
   localparam int FORCED_BAD_FRAME = 3;
   localparam int BIT_TIME         = CLKS_PER_BIT * CLK_PERIOD;
   // Longest frame plus gap is 13 bit times
   // Extra frames cover the drain waits
   localparam int TIMEOUT = (PHASE1_FRAMES + PHASE2_FRAMES + 8) * 14 * BIT_TIME
                            + 2 * (RESET_CYCLES + STRETCH_CYCLES + 2) * CLK_PERIOD;
   localparam logic [31:0] LFSR_SEED = 32'h65e3_68ae;
   localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

   logic        sysclk;
   logic        arst;
   logic        uart_rxd;
   wire         uart_txd;
   wire         trap;

   logic [31:0] lfsr_q;
   logic        reset_phase;
   logic        model_trap;
   byte_t       expected_q[$];
   int          mismatch_count;
   int          fail_count;

   top_system #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .RESET_CNT_W  (RESET_CNT_W)
   ) dut0 (
      .sysclk   (sysclk),
      .arst     (arst),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .trap     (trap)
   );

   initial begin
      sysclk = 1'b0;
      forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ LFSR_POLY;
      end
      return n;
   endfunction

   // One LFSR step per bit taken
   task automatic draw_bits(input int count, output logic [31:0] value);
      value = '0;
      for (int k = 0; k < count; k++) begin
         value  = {value[30:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
   endtask

   task automatic drive_bit(input logic value);
      uart_rxd = value;
      repeat (CLKS_PER_BIT) @(negedge sysclk);
   endtask

   task automatic apply_reset();
      arst = 1'b1;
      @(negedge sysclk);
      reset_phase = 1'b1;
      repeat (RESET_CYCLES - 1) @(negedge sysclk);
      arst = 1'b0;
      // A start bit inside the stretch must not reach the receiver
      drive_bit(1'b0);
      uart_rxd = 1'b1;
      // Rest of the stretch plus one cycle of margin
      repeat (STRETCH_CYCLES + 1 - CLKS_PER_BIT) @(negedge sysclk);
      reset_phase = 1'b0;
   endtask

   task automatic send_frame(input byte_t data, input logic bad_stop);
      assert (trap === model_trap) else begin
         mismatch_count++;
         $display("MISMATCH trap: expected 1'h%h, got 1'h%h", model_trap, trap);
      end
      if (!bad_stop) begin
         expected_q.push_back(data);
      end
      drive_bit(1'b0);
      for (int k = 0; k < 8; k++) begin
         drive_bit(data[k]);
      end
      drive_bit(~bad_stop);
      if (bad_stop) begin
         model_trap = 1'b1;
      end
   endtask

   task automatic run_frames(input int count, input int forced_bad);
      logic [31:0] data_bits;
      logic [31:0] gap_bits;
      logic [31:0] bad_bits;
      int          gap;
      logic        bad;
      for (int i = 0; i < count; i++) begin
         draw_bits(8, data_bits);
         draw_bits(2, gap_bits);
         draw_bits(4, bad_bits);
         bad = (bad_bits[3:0] == 4'd0) || (i == forced_bad);
         gap = int'(gap_bits[1:0]);
         // Line must return high after a low stop bit
         if (bad && gap == 0) begin
            gap = 1;
         end
         send_frame(data_bits[7:0], bad);
         repeat (gap) drive_bit(1'b1);
      end
   endtask

   task automatic wait_for_echoes();
      while (expected_q.size() != 0) begin
         @(negedge sysclk);
      end
      repeat (CLKS_PER_BIT) @(negedge sysclk);
   endtask

   task automatic print_counts();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
   endtask

   // Outputs held inactive through reset and stretch
   initial begin : reset_watch
      forever begin
         @(negedge sysclk);
         if (reset_phase) begin
            assert (uart_txd === 1'b1) else begin
               mismatch_count++;
               $display("MISMATCH uart_txd in reset: expected 1'h1, got 1'h%h", uart_txd);
            end
            assert (trap === 1'b0) else begin
               mismatch_count++;
               $display("MISMATCH trap in reset: expected 1'h0, got 1'h%h", trap);
            end
         end
      end
   end

   // Serial decoder on the echo line samples at mid-bit
   initial begin : decode_tx
      byte_t got;
      byte_t exp;
      forever begin
         @(negedge sysclk);
         if (uart_txd === 1'b0 && !reset_phase) begin
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge sysclk);
            assert (uart_txd === 1'b0) else begin
               fail_count++;
               $display("ERROR: start bit on uart_txd ended before mid-bit");
            end
            for (int k = 0; k < 8; k++) begin
               repeat (CLKS_PER_BIT) @(negedge sysclk);
               got[k] = uart_txd;
            end
            repeat (CLKS_PER_BIT) @(negedge sysclk);
            assert (uart_txd === 1'b1) else begin
               mismatch_count++;
               $display("MISMATCH uart_txd stop bit: expected 1'h1, got 1'h%h", uart_txd);
            end
            if (expected_q.size() == 0) begin
               fail_count++;
               $display("ERROR: byte %02h echoed although no good byte was pending", got);
            end else begin
               exp = expected_q.pop_front();
               assert (got === exp) else begin
                  mismatch_count++;
                  $display("MISMATCH uart_txd data: expected 8'h%02h, got 8'h%02h", exp, got);
               end
            end
         end
      end
   end

   initial begin : watchdog
      #(TIMEOUT);
      $display("ERROR: watchdog expired, %0d echoes still pending", expected_q.size());
      print_counts();
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      arst           = 1'b1;
      uart_rxd       = 1'b1;
      reset_phase    = 1'b0;
      model_trap     = 1'b0;
      lfsr_q         = LFSR_SEED;
      mismatch_count = 0;
      fail_count     = 0;
      apply_reset();

      run_frames(PHASE1_FRAMES, FORCED_BAD_FRAME);
      wait_for_echoes();

      // Second board reset clears trap
      apply_reset();
      model_trap = 1'b0;
      assert (trap === 1'b0) else begin
         mismatch_count++;
         $display("MISMATCH trap after reset: expected 1'h0, got 1'h%h", trap);
      end

      run_frames(PHASE2_FRAMES, -1);
      wait_for_echoes();
      // Room for a stray echo to show up
      repeat (12 * CLKS_PER_BIT) @(negedge sysclk);
      assert (trap === model_trap) else begin
         mismatch_count++;
         $display("MISMATCH trap at end: expected 1'h%h, got 1'h%h", model_trap, trap);
      end

      print_counts();
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: uart_echo_board.f
source/board_pkg.sv
source/reset_stretch.sv
source/uart_rx.sv
source/uart_tx.sv
source/system.sv
source/top_system.sv
verification/tb_top_system.sv

// File: Bender.yml
package:
  name: uart_echo_board

sources:
  - files:
      - source/board_pkg.sv
      - source/reset_stretch.sv
      - source/uart_rx.sv
      - source/uart_tx.sv
      - source/system.sv
      - source/top_system.sv

  - target: test
    files:
      - verification/tb_top_system.sv

__EOF__
